/* csr_unit.sv */
/*
 * Four scratch CSRs. Opcode 1 writes, 2 sets and 3 clears bits, and 0 only reads.
 * done_o and the old value follow a request by exactly one cycle.
 * An unknown address raises excp_o and leaves every register unchanged.
 */
`default_nettype none
`include "mem_sched_consts.svh"

module csr_unit
    import mem_sched_pkg::*;
(
    input  wire logic     cpu_clk_i,
    input  wire logic     rst_i,
    input  wire logic     req_valid_i,
    input  wire csr_req_t req_i,
    output logic          done_o,
    output word_t         rdata_o,
    output logic          excp_o
);
    word_t      csr_q [4];
    logic       hit;
    logic [1:0] idx;
    word_t      old_val;
    word_t      new_val;

    always_comb begin
        hit = 1'b1;
        idx = 2'd0;
        case (req_i.addr)
            `MS_CSR_SCRATCH0: idx = 2'd0;
            `MS_CSR_SCRATCH1: idx = 2'd1;
            `MS_CSR_SCRATCH2: idx = 2'd2;
            `MS_CSR_SCRATCH3: idx = 2'd3;
            default:          hit = 1'b0;
        endcase
    end

    assign old_val = csr_q[idx];

    always_comb begin
        case (req_i.opcode)
            2'd1:    new_val = req_i.data;
            2'd2:    new_val = old_val | req_i.data;
            2'd3:    new_val = old_val & ~req_i.data;
            default: new_val = old_val;
        endcase
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 4; i++) begin
                csr_q[i] <= '0;
            end
        end else if (req_valid_i && hit && req_i.wr_en) begin
            csr_q[idx] <= new_val;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            done_o <= 1'b0;
            excp_o <= 1'b0;
        end else begin
            done_o <= req_valid_i;
            excp_o <= req_valid_i & ~hit;
        end
    end

    // Value before the update
    always_ff @(posedge cpu_clk_i) begin
        if (req_valid_i) begin
            rdata_o <= hit ? old_val : '0;
        end
    end

endmodule

`default_nettype wire

/* issue_fifo.sv */
/*
 * Issue queue of renamer packets, MS_FIFO_DEPTH entries deep.
 * A push while full is dropped, so the producer must hold its packet.
 * The head packet is read combinationally. Flush empties the queue at the next edge.
 */
`default_nettype none
`include "mem_sched_consts.svh"

module issue_fifo
    import mem_sched_pkg::*;
(
    input  wire logic    cpu_clk_i,
    input  wire logic    rst_i,
    input  wire logic    flush_i,
    input  wire logic    push_i,
    input  wire packet_t push_pkt_i,
    input  wire logic    pop_i,
    output packet_t      head_pkt_o,
    output logic         full_o,
    output logic         empty_o
);
    localparam int PTR_W = $clog2(`MS_FIFO_DEPTH);

    packet_t          mem_q [`MS_FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o     = (count_q == (PTR_W + 1)'(`MS_FIFO_DEPTH));
    assign empty_o    = (count_q == '0);
    assign do_push    = push_i & ~full_o & ~flush_i;
    assign do_pop     = pop_i & ~empty_o & ~flush_i;
    assign head_pkt_o = mem_q[rd_ptr_q];

    always_ff @(posedge cpu_clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_pkt_i;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* mem_sched_consts.svh */
/*
 * Sizing constants, CSR addresses and op type bit positions for the memory scheduler.
 * The FIFO depth must stay a power of two, because the pointers wrap naturally.
 * Type bits index the one-hot op class that the renamer produces.
 */
`ifndef MEM_SCHED_CONSTS_SVH
`define MEM_SCHED_CONSTS_SVH

`define MS_FIFO_DEPTH   8
`define MS_NUM_PREGS    64

// Scratch CSRs in the custom machine read/write range
`define MS_CSR_SCRATCH0 12'h7C0
`define MS_CSR_SCRATCH1 12'h7C1
`define MS_CSR_SCRATCH2 12'h7C2
`define MS_CSR_SCRATCH3 12'h7C3

`define MS_TYPE_FENCE   1
`define MS_TYPE_CSR     2
`define MS_TYPE_STORE   3
`define MS_TYPE_LOAD    4

`endif

/* mem_sched_patterns.txt */
# cmd, hex fields: W reg data | P reg | K id t0 op0 rs1 rs2 dst imm [t1 op1 rs1 rs2 dst imm]
# A addr data dest rob op store | C rob | X rob | N/I cycles | S | B/G/O/U value | F
W 05 00001000
K 01 10 2 05 00 0a 00000010
A 00001010 00000000 0a 02 2 0
P 07
W 06 00002000
K 02 10 0 06 00 0b 00000004 08 2 06 07 00 00000008
A 00002004 00000000 0b 04 0 0
N 6
W 07 0000beef
A 00002008 0000beef 00 05 a 1
K 03 10 2 05 00 0c 00000000
K 04 10 2 06 00 0d 00000000
I 1
S
A 00001000 00000000 0c 06 2 0
A 00002000 00000000 0d 08 2 0
K 05 04 1 05 00 0e 000007c0
N 5
O 05
C 0a
K 06 04 1 06 00 0f 000007c0
O 06
C 0c
K 07 10 2 0f 00 10 00000000
A 00001000 00000000 10 0e 2 0
K 08 04 1 05 00 11 00000123
O 08
X 10
G 0
K 09 02 0 00 00 00 00000000
O 09
N 6
G 1
C 12
B 1
K 0a 10 2 05 00 01 00000000
K 0b 10 2 05 00 01 00000000
K 0c 10 2 05 00 01 00000000
K 0d 10 2 05 00 01 00000000
K 0e 10 2 05 00 01 00000000
K 0f 10 2 05 00 01 00000000
K 10 10 2 05 00 01 00000000
K 11 10 2 05 00 01 00000000
U 1
F
B 0
N 8
U 0

/* mem_sched_pkg.sv */
/*
 * Shared types of the memory and system issue stage.
 * Slot fields follow the renamer packet layout. A rob tag is the packet id
 * with the slot index appended as its low bit.
 */
`default_nettype none

package mem_sched_pkg;

    typedef logic [5:0]  preg_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  rob_id_t;
    typedef logic [5:0]  rob_tag_t;
    typedef logic [5:0]  op_type_t;
    typedef logic [11:0] csr_addr_t;

    // One micro-op as delivered by the renamer
    typedef struct packed {
        preg_t      rs1;
        preg_t      rs2;
        preg_t      dest;
        word_t      imm;
        op_type_t   op_type;
        logic [2:0] opcode;
        logic       valid;
    } slot_t;

    typedef struct packed {
        slot_t   slot1;
        slot_t   slot0;
        rob_id_t rob_id;
    } packet_t;

    // Request to the load/store unit, op is {store, opcode}
    typedef struct packed {
        word_t      addr;
        word_t      data;
        preg_t      dest;
        rob_tag_t   rob;
        logic [3:0] op;
        logic       store;
    } lsu_req_t;

    typedef struct packed {
        csr_addr_t  addr;
        word_t      data;
        logic [1:0] opcode;
        logic       wr_en;
    } csr_req_t;

    typedef enum logic {
        FENCE_IDLE,
        FENCE_DRAIN
    } fence_state_t;

endpackage

`default_nettype wire

/* mem_sched_sva.sv */
/*
 * Assertions on the top-level LSU and completion outputs of the memory scheduler.
 * Bound into every instance of the top level. Checks are disabled while reset is high,
 * except the check of the cycle right after a reset edge.
 */
`default_nettype none

module mem_sched_sva
    import mem_sched_pkg::*;
(
    input wire logic     cpu_clk_i,
    input wire logic     rst_i,
    input wire logic     lsu_valid_o,
    input wire logic     lsu_busy_i,
    input wire lsu_req_t lsu_req_o,
    input wire logic     completion_valid_o,
    input wire logic     exception_o
);

    // Outputs come out of reset quiet
    reset_quiet: assert property (@(posedge cpu_clk_i)
        rst_i |=> (!lsu_valid_o && !completion_valid_o))
        else $error("LSU valid or completion high right after reset");

    // A held request must not change under back-pressure
    req_stable: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        (lsu_valid_o && lsu_busy_i) |=> $stable(lsu_req_o))
        else $error("LSU request changed while the LSU was busy");

    excp_alone: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        exception_o |-> !completion_valid_o)
        else $error("Exception reported together with a completion");

endmodule

bind mem_sched_top mem_sched_sva u_mem_sched_sva (
    .cpu_clk_i          (cpu_clk_i),
    .rst_i              (rst_i),
    .lsu_valid_o        (lsu_valid_o),
    .lsu_busy_i         (lsu_busy_i),
    .lsu_req_o          (lsu_req_o),
    .completion_valid_o (completion_valid_o),
    .exception_o        (exception_o)
);

`default_nettype wire

/* mem_sched_top.sv */
/*
 * Memory and system issue stage. Renamer, ROB, LSU and store buffer sit outside.
 * The CSR block and register file are internal, so an old CSR value is seen only by a
 * later op that reads its destination register. No cycles are added at this level.
 */
`default_nettype none

module mem_sched_top
    import mem_sched_pkg::*;
(
    input  wire logic    cpu_clk_i,
    input  wire logic    rst_i,
    input  wire logic    flush_i,
    input  wire logic    renamer_valid_i,
    input  wire packet_t renamer_pkt_i,
    input  wire logic    pend_valid_i,
    input  wire preg_t   pend_dest_i,
    input  wire logic    wb_valid_i,
    input  wire preg_t   wb_dest_i,
    input  wire word_t   wb_data_i,
    input  wire logic    lsu_busy_i,
    input  wire logic    rob_lock_i,
    input  wire rob_id_t rob_oldest_i,
    input  wire logic    store_buffer_empty_i,
    output logic         full_o,
    output logic         lsu_valid_o,
    output lsu_req_t     lsu_req_o,
    output logic         completion_valid_o,
    output rob_tag_t     completion_rob_o,
    output logic         exception_o,
    output rob_tag_t     exception_rob_o
);
    packet_t  head_pkt;
    logic     fifo_empty;
    logic     sched_pop;
    preg_t    rs1_idx;
    preg_t    rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     rs1_ready;
    logic     rs2_ready;
    logic     csr_valid;
    csr_req_t csr_req;
    logic     csr_done;
    word_t    csr_rdata;
    logic     csr_excp;
    logic     prf_we;
    preg_t    prf_dest;
    word_t    prf_data;

    issue_fifo u_issue_fifo (
        .cpu_clk_i  (cpu_clk_i),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .push_i     (renamer_valid_i),
        .push_pkt_i (renamer_pkt_i),
        .pop_i      (sched_pop),
        .head_pkt_o (head_pkt),
        .full_o     (full_o),
        .empty_o    (fifo_empty)
    );

    mem_scheduler u_mem_scheduler (
        .cpu_clk_i            (cpu_clk_i),
        .rst_i                (rst_i),
        .flush_i              (flush_i),
        .head_pkt_i           (head_pkt),
        .empty_i              (fifo_empty),
        .rs1_data_i           (rs1_data),
        .rs2_data_i           (rs2_data),
        .rs1_ready_i          (rs1_ready),
        .rs2_ready_i          (rs2_ready),
        .lsu_busy_i           (lsu_busy_i),
        .rob_lock_i           (rob_lock_i),
        .rob_oldest_i         (rob_oldest_i),
        .store_buffer_empty_i (store_buffer_empty_i),
        .csr_done_i           (csr_done),
        .csr_rdata_i          (csr_rdata),
        .csr_excp_i           (csr_excp),
        .pop_o                (sched_pop),
        .rs1_o                (rs1_idx),
        .rs2_o                (rs2_idx),
        .lsu_valid_o          (lsu_valid_o),
        .lsu_req_o            (lsu_req_o),
        .csr_valid_o          (csr_valid),
        .csr_req_o            (csr_req),
        .prf_we_o             (prf_we),
        .prf_dest_o           (prf_dest),
        .prf_data_o           (prf_data),
        .completion_valid_o   (completion_valid_o),
        .completion_rob_o     (completion_rob_o),
        .exception_o          (exception_o),
        .exception_rob_o      (exception_rob_o)
    );

    csr_unit u_csr_unit (
        .cpu_clk_i   (cpu_clk_i),
        .rst_i       (rst_i),
        .req_valid_i (csr_valid),
        .req_i       (csr_req),
        .done_o      (csr_done),
        .rdata_o     (csr_rdata),
        .excp_o      (csr_excp)
    );

    // Port A takes load returns, port B the CSR writeback
    reg_status u_reg_status (
        .cpu_clk_i    (cpu_clk_i),
        .rst_i        (rst_i),
        .rs1_i        (rs1_idx),
        .rs2_i        (rs2_idx),
        .wa_valid_i   (wb_valid_i),
        .wa_dest_i    (wb_dest_i),
        .wa_data_i    (wb_data_i),
        .wb_valid_i   (prf_we),
        .wb_dest_i    (prf_dest),
        .wb_data_i    (prf_data),
        .pend_valid_i (pend_valid_i),
        .pend_dest_i  (pend_dest_i),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .rs1_ready_o  (rs1_ready),
        .rs2_ready_o  (rs2_ready)
    );

endmodule

`default_nettype wire

/* mem_scheduler.sv */
/*
 * Picks the oldest slot of the head packet and issues it.
 * Loads and stores go to the LSU as a registered request held while lsu_busy_i is high.
 * CSR ops and fences wait until their packet is oldest in the ROB, and retire on
 * csr_done or an empty store buffer. Only one system op is in flight at a time.
 */
`default_nettype none
`include "mem_sched_consts.svh"

module mem_scheduler
    import mem_sched_pkg::*;
(
    input  wire logic    cpu_clk_i,
    input  wire logic    rst_i,
    input  wire logic    flush_i,
    input  wire packet_t head_pkt_i,
    input  wire logic    empty_i,
    input  wire word_t   rs1_data_i,
    input  wire word_t   rs2_data_i,
    input  wire logic    rs1_ready_i,
    input  wire logic    rs2_ready_i,
    input  wire logic    lsu_busy_i,
    input  wire logic    rob_lock_i,
    input  wire rob_id_t rob_oldest_i,
    input  wire logic    store_buffer_empty_i,
    input  wire logic    csr_done_i,
    input  wire word_t   csr_rdata_i,
    input  wire logic    csr_excp_i,
    output logic         pop_o,
    output preg_t        rs1_o,
    output preg_t        rs2_o,
    output logic         lsu_valid_o,
    output lsu_req_t     lsu_req_o,
    output logic         csr_valid_o,
    output csr_req_t     csr_req_o,
    output logic         prf_we_o,
    output preg_t        prf_dest_o,
    output word_t        prf_data_o,
    output logic         completion_valid_o,
    output rob_tag_t     completion_rob_o,
    output logic         exception_o,
    output rob_tag_t     exception_rob_o
);
    logic         slot_ptr_q;
    logic         csr_pend_q;
    fence_state_t fence_q;
    logic         both_valid;
    logic         no_valid;
    logic         slot_sel;
    slot_t        act;
    rob_tag_t     act_tag;
    logic         is_load;
    logic         is_store;
    logic         is_fence;
    logic         is_csr;
    logic         is_sys;
    logic         slot_live;
    logic         rs1_ok;
    logic         rs2_ok;
    logic         is_oldest;
    logic         sys_busy;
    logic         mem_issue;
    logic         lsu_launch;
    logic         csr_launch;
    logic         csr_hit;
    logic         fence_hit;
    logic         sys_done;
    logic         advance;

    // Slot 1 is taken directly when slot 0 is empty
    assign both_valid = head_pkt_i.slot0.valid & head_pkt_i.slot1.valid;
    assign no_valid   = ~(head_pkt_i.slot0.valid | head_pkt_i.slot1.valid);
    assign slot_sel   = slot_ptr_q | (~head_pkt_i.slot0.valid & head_pkt_i.slot1.valid);
    assign act        = slot_sel ? head_pkt_i.slot1 : head_pkt_i.slot0;
    assign act_tag    = {head_pkt_i.rob_id, slot_sel};

    assign is_load  = act.op_type[`MS_TYPE_LOAD];
    assign is_store = act.op_type[`MS_TYPE_STORE];
    assign is_fence = act.op_type[`MS_TYPE_FENCE];
    assign is_csr   = act.op_type[`MS_TYPE_CSR];
    assign is_sys   = is_fence | is_csr;

    assign rs1_o = act.rs1;
    assign rs2_o = act.rs2;

    // Immediate CSR forms carry a constant in the rs1 field
    assign slot_live = ~empty_i & act.valid;
    assign rs1_ok    = rs1_ready_i | (is_csr & act.opcode[2]);
    assign rs2_ok    = rs2_ready_i | ~is_store;
    assign is_oldest = (head_pkt_i.rob_id == rob_oldest_i) & ~rob_lock_i;
    assign sys_busy  = csr_pend_q | (fence_q == FENCE_DRAIN);

    assign mem_issue  = slot_live & ~is_sys & rs1_ok & rs2_ok & ~lsu_busy_i
                      & ~rob_lock_i & ~flush_i & ~sys_busy;
    assign lsu_launch = mem_issue & (is_load | is_store);
    assign csr_launch = slot_live & is_csr & is_oldest & rs1_ok & ~csr_pend_q & ~flush_i;

    assign csr_hit   = csr_pend_q & csr_done_i;
    assign fence_hit = (fence_q == FENCE_DRAIN) & store_buffer_empty_i;
    assign sys_done  = csr_hit | fence_hit;
    assign advance   = (mem_issue | sys_done) & ~flush_i;

    // Pop on the last valid slot, or drop a packet that carries no valid slot
    assign pop_o = ~flush_i & ~empty_i
                 & ((advance & ~(both_valid & ~slot_ptr_q)) | no_valid);

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i || flush_i) begin
            slot_ptr_q <= 1'b0;
        end else if (advance) begin
            slot_ptr_q <= both_valid & ~slot_ptr_q;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i || flush_i) begin
            lsu_valid_o <= 1'b0;
        end else if (lsu_launch) begin
            lsu_valid_o <= 1'b1;
        end else if (!lsu_busy_i) begin
            lsu_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (lsu_launch) begin
            lsu_req_o.addr  <= rs1_data_i + act.imm;
            lsu_req_o.data  <= rs2_data_i;
            lsu_req_o.dest  <= act.dest;
            lsu_req_o.rob   <= act_tag;
            lsu_req_o.op    <= {is_store, act.opcode};
            lsu_req_o.store <= is_store;
        end
    end

    // CSR request pulses once; pending holds the slot until done returns
    always_ff @(posedge cpu_clk_i) begin
        if (rst_i || flush_i) begin
            csr_valid_o <= 1'b0;
            csr_pend_q  <= 1'b0;
        end else begin
            csr_valid_o <= csr_launch;
            if (csr_launch) begin
                csr_pend_q <= 1'b1;
            end else if (csr_done_i) begin
                csr_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (csr_launch) begin
            csr_req_o.addr   <= act.imm[11:0];
            csr_req_o.data   <= act.opcode[2] ? word_t'(act.rs1) : rs1_data_i;
            csr_req_o.opcode <= act.opcode[1:0];
            csr_req_o.wr_en  <= (act.rs1 != '0) | act.opcode[2];
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i || flush_i) begin
            fence_q <= FENCE_IDLE;
        end else begin
            case (fence_q)
                FENCE_IDLE: begin
                    if (slot_live && is_fence && is_oldest) begin
                        fence_q <= FENCE_DRAIN;
                    end
                end
                FENCE_DRAIN: begin
                    if (store_buffer_empty_i) begin
                        fence_q <= FENCE_IDLE;
                    end
                end
                default: fence_q <= FENCE_IDLE;
            endcase
        end
    end

    // Old CSR value goes back to the register file in the done cycle
    assign prf_we_o   = csr_hit & ~csr_excp_i & (act.dest != '0);
    assign prf_dest_o = act.dest;
    assign prf_data_o = csr_rdata_i;

    assign exception_o        = csr_hit & csr_excp_i;
    assign exception_rob_o    = act_tag;
    assign completion_valid_o = fence_hit | (csr_hit & ~csr_excp_i);
    assign completion_rob_o   = act_tag;

endmodule

`default_nettype wire

/* project.f */
+incdir+.
mem_sched_pkg.sv
issue_fifo.sv
mem_scheduler.sv
csr_unit.sv
reg_status.sv
mem_sched_top.sv
mem_sched_sva.sv
tb_mem_sched.sv

/* reg_status.sv */
/*
 * Physical register file with a ready bit per register.
 * Two read ports are combinational. Two write ports each set the ready bit, and
 * when both hit one register port A wins. A write beats a pending mark in the same cycle.
 * Register 0 always reads as zero and ready.
 */
`default_nettype none
`include "mem_sched_consts.svh"

module reg_status
    import mem_sched_pkg::*;
(
    input  wire logic  cpu_clk_i,
    input  wire logic  rst_i,
    input  wire preg_t rs1_i,
    input  wire preg_t rs2_i,
    input  wire logic  wa_valid_i,
    input  wire preg_t wa_dest_i,
    input  wire word_t wa_data_i,
    input  wire logic  wb_valid_i,
    input  wire preg_t wb_dest_i,
    input  wire word_t wb_data_i,
    input  wire logic  pend_valid_i,
    input  wire preg_t pend_dest_i,
    output word_t      rs1_data_o,
    output word_t      rs2_data_o,
    output logic       rs1_ready_o,
    output logic       rs2_ready_o
);
    word_t                    data_q [`MS_NUM_PREGS];
    logic [`MS_NUM_PREGS-1:0] ready_q;

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `MS_NUM_PREGS; i++) begin
                data_q[i] <= '0;
            end
            ready_q <= '1;
        end else begin
            // Later assignments take priority
            if (pend_valid_i) begin
                ready_q[pend_dest_i] <= 1'b0;
            end
            if (wb_valid_i) begin
                data_q[wb_dest_i]  <= wb_data_i;
                ready_q[wb_dest_i] <= 1'b1;
            end
            if (wa_valid_i) begin
                data_q[wa_dest_i]  <= wa_data_i;
                ready_q[wa_dest_i] <= 1'b1;
            end
        end
    end

    assign rs1_data_o  = (rs1_i == '0) ? '0 : data_q[rs1_i];
    assign rs2_data_o  = (rs2_i == '0) ? '0 : data_q[rs2_i];
    assign rs1_ready_o = (rs1_i == '0) | ready_q[rs1_i];
    assign rs2_ready_o = (rs2_i == '0) | ready_q[rs2_i];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass message appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module tb_mem_sched \
    -Mdir obj_dir -o sim_mem_sched &&
./obj_dir/sim_mem_sched | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* tb_mem_sched.sv */
/*
 * Testbench for the memory scheduler top level, driven by mem_sched_patterns.txt.
 * Must run from the project root. Holds at most 64 pattern lines.
 * Inputs change one time unit after the rising edge, outputs are sampled at the falling edge.
 */
`default_nettype none

module tb_mem_sched
    import mem_sched_pkg::*;
();
    localparam int MAX_LINES = 64;

    logic      cpu_clk_i = 1'b0;
    logic      rst_i = 1'b1;
    logic      flush_i = 1'b0;
    logic      renamer_valid_i = 1'b0;
    packet_t   renamer_pkt_i = '0;
    logic      pend_valid_i = 1'b0;
    preg_t     pend_dest_i = '0;
    logic      wb_valid_i = 1'b0;
    preg_t     wb_dest_i = '0;
    word_t     wb_data_i = '0;
    logic      lsu_busy_i = 1'b0;
    logic      rob_lock_i = 1'b0;
    rob_id_t   rob_oldest_i = '0;
    logic      store_buffer_empty_i = 1'b1;
    logic      full_o;
    logic      lsu_valid_o;
    lsu_req_t  lsu_req_o;
    logic      completion_valid_o;
    rob_tag_t  completion_rob_o;
    logic      exception_o;
    rob_tag_t  exception_rob_o;

    byte         cmd [MAX_LINES];
    logic [31:0] fld [MAX_LINES][13];
    int          num_lines = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 2000;
    logic [31:0] rng_state = 32'h81e3;
    lsu_req_t    req_q[$];
    rob_tag_t    comp_q[$];
    rob_tag_t    exc_q[$];

    mem_sched_top u_mem_sched_top (.*);

    always #2 cpu_clk_i = ~cpu_clk_i;

    always @(posedge cpu_clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // An LSU request is handed over in a cycle where it is valid and the LSU is free
    always @(negedge cpu_clk_i) begin
        if (!rst_i) begin
            if (lsu_valid_o && !lsu_busy_i) begin
                req_q.push_back(lsu_req_o);
            end
            if (completion_valid_o) begin
                comp_q.push_back(completion_rob_o);
            end
            if (exception_o) begin
                exc_q.push_back(exception_rob_o);
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic slot_t make_slot(input int idx, input int b);
        slot_t s;
        s.op_type = op_type_t'(fld[idx][b]);
        s.opcode  = fld[idx][b+1][2:0];
        s.rs1     = preg_t'(fld[idx][b+2]);
        s.rs2     = preg_t'(fld[idx][b+3]);
        s.dest    = preg_t'(fld[idx][b+4]);
        s.imm     = fld[idx][b+5];
        s.valid   = (fld[idx][b] != 32'd0);
        return s;
    endfunction

    task automatic check_req(input string name, input lsu_req_t exp, input lsu_req_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input rob_tag_t exp, input rob_tag_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            value_errors++;
            $display("ERROR %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge cpu_clk_i);
        #1;
    endtask

    task automatic load_patterns();
        int          fd;
        int          rc;
        string       line;
        byte         c;
        logic [31:0] a [13];
        fd = $fopen("mem_sched_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the pattern file");
        end else begin
            while (!$feof(fd) && num_lines < MAX_LINES) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 1 && line[0] != "#") begin
                    for (int k = 0; k < 13; k++) begin
                        a[k] = '0;
                    end
                    rc = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h", c,
                                 a[0], a[1], a[2], a[3], a[4], a[5], a[6],
                                 a[7], a[8], a[9], a[10], a[11], a[12]);
                    cmd[num_lines] = c;
                    for (int k = 0; k < 13; k++) begin
                        fld[num_lines][k] = a[k];
                    end
                    num_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Holds the LSU busy for a random number of cycles and watches the held request
    task automatic stall_lsu(input string name);
        int       n;
        logic     was_valid;
        lsu_req_t held;
        rng_state = xorshift(rng_state);
        n = 2 + int'(rng_state % 32'd5);
        lsu_busy_i = 1'b1;
        was_valid = lsu_valid_o;
        held = lsu_req_o;
        repeat (n) begin
            next_cycle();
            check_flag({name, " valid held"}, was_valid, lsu_valid_o);
            if (was_valid) begin
                check_req({name, " request held"}, held, lsu_req_o);
            end
        end
        lsu_busy_i = 1'b0;
    endtask

    task automatic run_step(input int i);
        string    name;
        lsu_req_t exp;
        rob_tag_t tag;
        name = $sformatf("step %0d (%c)", i, cmd[i]);
        case (cmd[i])
            "W": begin
                wb_valid_i = 1'b1;
                wb_dest_i  = preg_t'(fld[i][0]);
                wb_data_i  = fld[i][1];
                next_cycle();
                wb_valid_i = 1'b0;
            end
            "P": begin
                pend_valid_i = 1'b1;
                pend_dest_i  = preg_t'(fld[i][0]);
                next_cycle();
                pend_valid_i = 1'b0;
            end
            "K": begin
                renamer_pkt_i.rob_id = rob_id_t'(fld[i][0]);
                renamer_pkt_i.slot0  = make_slot(i, 1);
                renamer_pkt_i.slot1  = make_slot(i, 7);
                renamer_valid_i = 1'b1;
                next_cycle();
                renamer_valid_i = 1'b0;
            end
            "A": begin
                while (req_q.size() == 0) begin
                    next_cycle();
                end
                exp.addr  = fld[i][0];
                exp.data  = fld[i][1];
                exp.dest  = preg_t'(fld[i][2]);
                exp.rob   = rob_tag_t'(fld[i][3]);
                exp.op    = fld[i][4][3:0];
                exp.store = fld[i][5][0];
                check_req(name, exp, req_q.pop_front());
            end
            "C": begin
                while (comp_q.size() == 0) begin
                    next_cycle();
                end
                check_tag(name, rob_tag_t'(fld[i][0]), comp_q.pop_front());
            end
            "X": begin
                while (exc_q.size() == 0) begin
                    next_cycle();
                end
                tag = exc_q.pop_front();
                check_tag(name, rob_tag_t'(fld[i][0]), tag);
            end
            "N": begin
                repeat (int'(fld[i][0])) next_cycle();
                if (req_q.size() != 0 || comp_q.size() != 0 || exc_q.size() != 0) begin
                    other_errors++;
                    $display("%s: a request or completion appeared in a quiet window", name);
                    req_q.delete();
                    comp_q.delete();
                    exc_q.delete();
                end
            end
            "I": repeat (int'(fld[i][0])) next_cycle();
            "S": stall_lsu(name);
            "B": lsu_busy_i = fld[i][0][0];
            "G": store_buffer_empty_i = fld[i][0][0];
            "O": rob_oldest_i = rob_id_t'(fld[i][0]);
            "F": begin
                flush_i = 1'b1;
                next_cycle();
                flush_i = 1'b0;
            end
            "U": check_flag(name, fld[i][0][0], full_o);
            default: begin
                other_errors++;
                $display("%s: unknown command in the pattern file", name);
            end
        endcase
    endtask

    initial begin
        load_patterns();
        cycle_limit = 40 * (num_lines + 1);
        repeat (5) @(posedge cpu_clk_i);
        #1;
        rst_i = 1'b0;
        for (int i = 0; i < num_lines; i++) begin
            run_step(i);
        end
        repeat (4) next_cycle();
        if (req_q.size() != 0 || comp_q.size() != 0 || exc_q.size() != 0) begin
            other_errors++;
            $display("Unexpected requests or completions were left at the end of the run");
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
